// File: Makefile
TOP = tb_adc_trigger

sim:
	verilator --binary --timing --assert -Wno-fatal -f adc_trigger_top.f --top-module $(TOP) -o sim_$(TOP) --Mdir obj_dir
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: adc_trigger_top.f
hdl/trg_pkg.sv
hdl/run_control.sv
hdl/baseline_calib.sv
hdl/threshold_trigger.sv
hdl/event_recorder.sv
hdl/adc_trigger_top.sv
bench/tb_clock.sv
bench/tb_adc_trigger.sv

// File: bench/tb_adc_trigger.sv
`timescale 1ns/100ps

module tb_adc_trigger;

    localparam int MAX_CYC     = 1024;
    localparam int THRESH_VAL  = 4095 * 10 / 100;
    localparam int POST_LEN    = 38;
    localparam int CAP_LEN     = 100;
    localparam int CALIB_BEATS = 16;

    logic AXIS_ACLK;
    logic AXIS_ARESETN;
    logic start;
    logic stop;
    logic triggered;
    logic event_valid;
    trg_pkg::adc_beat_t   s_axis_tdata;
    trg_pkg::exec_state_e exec_state;
    trg_pkg::exec_state_e prev_state = trg_pkg::EXEC_IDLE;
    trg_pkg::trg_event_t  event_rec;
    logic signed [trg_pkg::ADC_RESOLUTION_WIDTH-1:0] baseline;
    logic signed [trg_pkg::ADC_RESOLUTION_WIDTH-1:0] ref_base;

    // recorded stimulus, one entry per clock
    trg_pkg::adc_beat_t beat_rec [MAX_CYC];
    logic start_rec [MAX_CYC];
    logic stop_rec [MAX_CYC];

    // expected results, consumed in order
    logic signed [trg_pkg::ADC_RESOLUTION_WIDTH-1:0] base_exp [$];
    trg_pkg::trg_event_t event_exp [$];

    // expected exec_state and triggered, indexed by beat
    trg_pkg::exec_state_e state_exp [MAX_CYC];
    logic trig_exp [MAX_CYC];

    int n_cyc = 0;
    int beat_idx = 0;
    int seed = 32'h7b81;
    int cycles = 0;
    int limit = 2 * MAX_CYC + 200;

    tb_clock i_tb_clock (.clk(AXIS_ACLK));

    adc_trigger_top i_adc_trigger_top (.*);

    // hot beats with one lane at hot_val, then quiet beats of noise around offset
    task automatic add_beats(input int offset, input int hot_beats, input int hot_lane,
                             input int hot_val, input int quiet, input logic go = 1'b0,
                             input logic halt = 1'b0);
        int sample;
        for (int b = 0; b < hot_beats + quiet; b++)
        begin
            for (int l = 0; l < trg_pkg::SAMPLES_PER_BEAT; l++)
            begin
                sample = (b < hot_beats && l == hot_lane) ? hot_val : offset + $random(seed) % 8;
                // padding bits are random too
                beat_rec[n_cyc].lane[l] = {4'($random(seed)), 12'(sample)};
            end
            start_rec[n_cyc] = go;
            stop_rec[n_cyc] = halt;
            n_cyc++;
        end
    endtask

    // walks the record with the run, calibration and window rules
    function automatic void run_reference(input int upto);
        trg_pkg::exec_state_e st = trg_pkg::EXEC_IDLE;
        int calib_cnt = 0;
        int acc = 0;
        int t0 = 0;
        int ts = 0;
        int len = 0;
        int post = 0;
        int pk = 0;
        int diff;
        int bmax;
        int bsum;
        logic hot;
        logic open = 1'b0;
        ref_base = '0;
        base_exp.delete();
        event_exp.delete();
        trig_exp[0] = 1'b0;
        trig_exp[1] = 1'b0;
        for (int n = 0; n < upto; n++)
        begin
            state_exp[n] = st;
            bmax = -8192;
            bsum = 0;
            for (int l = 0; l < trg_pkg::SAMPLES_PER_BEAT; l++)
            begin
                diff = $signed(beat_rec[n].lane[l][11:0]) - ref_base;
                bsum += $signed(beat_rec[n].lane[l][11:0]);
                bmax = (diff > bmax) ? diff : bmax;
            end
            hot = (st == trg_pkg::EXEC_TRG) && (bmax >= THRESH_VAL);
            if (open)
            begin
                len++;
                post = hot ? 0 : post + 1;
                pk = (bmax > pk) ? bmax : pk;
                if (post == POST_LEN || len == CAP_LEN)
                begin
                    // a quiet end on the cap beat is not over length
                    event_exp.push_back({16'(ts), 13'(pk), 10'(len), post != POST_LEN});
                    open = 1'b0;
                end
            end
            else if (hot)
            begin
                open = 1'b1;
                len = 1;
                post = 0;
                pk = bmax;
                ts = n - t0;
            end
            // triggered shows the window two cycles after the beat
            trig_exp[n + 2] = open;
            acc = (st == trg_pkg::EXEC_INIT) ? acc + bsum : 0;
            calib_cnt = (st == trg_pkg::EXEC_INIT) ? calib_cnt + 1 : 0;
            if (st != trg_pkg::EXEC_IDLE && stop_rec[n])
                st = trg_pkg::EXEC_IDLE;
            else if (st == trg_pkg::EXEC_IDLE && start_rec[n])
                st = trg_pkg::EXEC_INIT;
            else if (st == trg_pkg::EXEC_INIT && calib_cnt == CALIB_BEATS)
            begin
                st = trg_pkg::EXEC_TRG;
                // 16 beats of 8 samples
                ref_base = 12'(acc >>> 7);
                base_exp.push_back(ref_base);
                t0 = n + 1;
            end
        end
    endfunction

    task automatic check_state(input trg_pkg::exec_state_e got,
                               input trg_pkg::exec_state_e exp);
        if (got !== exp)
        begin
            $display("FAIL at %0d ns: exec_state %b, expected %b", $time, got, exp);
            $display(">>> FAIL");
            $fatal(1, "exec_state mismatch");
        end
    endtask

    task automatic check_triggered(input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAIL at %0d ns: triggered %b, expected %b", $time, got, exp);
            $display(">>> FAIL");
            $fatal(1, "triggered mismatch");
        end
    endtask

    task automatic check_baseline(input logic signed [trg_pkg::ADC_RESOLUTION_WIDTH-1:0] got,
                                  input logic signed [trg_pkg::ADC_RESOLUTION_WIDTH-1:0] exp);
        if (got !== exp)
        begin
            $display("FAIL at %0d ns: baseline %0d, expected %0d", $time, got, exp);
            $display(">>> FAIL");
            $fatal(1, "baseline mismatch");
        end
    endtask

    task automatic check_event(input trg_pkg::trg_event_t got, input trg_pkg::trg_event_t exp);
        if (got !== exp)
        begin
            $display("FAIL at %0d ns: event time %0d peak %0d length %0d over_len %0b",
                     $time, got.time_stamp, got.peak, got.length, got.over_len);
            $display("    expected time %0d peak %0d length %0d over_len %0b",
                     exp.time_stamp, exp.peak, exp.length, exp.over_len);
            $display(">>> FAIL");
            $fatal(1, "event record mismatch");
        end
    endtask

    // beats taken in since reset was released
    always @(posedge AXIS_ACLK)
    begin
        if (AXIS_ARESETN)
            beat_idx++;
    end

    // outputs read on the falling edge
    always @(negedge AXIS_ACLK)
    begin
        if (beat_idx < n_cyc)
        begin
            check_state(exec_state, state_exp[beat_idx]);
            check_triggered(triggered, trig_exp[beat_idx]);
        end
        if (exec_state == trg_pkg::EXEC_TRG && prev_state != trg_pkg::EXEC_TRG)
            check_baseline(baseline, base_exp.pop_front());
        if (event_valid === 1'b1)
        begin
            if (event_exp.size() == 0)
            begin
                $display("an event record came out with no expected record left");
                $display(">>> FAIL");
                $fatal(1, "unexpected event");
            end
            else
                check_event(event_rec, event_exp.pop_front());
        end
        prev_state = exec_state;
    end

    always @(posedge AXIS_ACLK)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("timeout, the run went past %0d cycles", limit);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        int edge_val;
        AXIS_ARESETN = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        s_axis_tdata = '0;
        // first run around a negative offset
        add_beats(0, 0, 0, 0, 2);
        add_beats(0, 0, 0, 0, 1, 1'b1);
        add_beats(-150, 0, 0, 0, 20);
        add_beats(-150, 3, 5, 450, 45);
        // one below the threshold, then exactly on it
        run_reference(n_cyc);
        edge_val = ref_base + THRESH_VAL;
        add_beats(-150, 5, 3, edge_val - 1, 10);
        add_beats(-150, 1, 3, edge_val, 45);
        // short gap merges, long gap splits
        add_beats(-150, 2, 1, 300, 20);
        add_beats(-150, 2, 6, 350, 45);
        add_beats(-150, 2, 0, 400, 50);
        add_beats(-150, 2, 4, 500, 45);
        // past the beat cap and on into a second window
        add_beats(-150, 130, 2, 380, 45);
        // stop, then a pulse while idle
        add_beats(-150, 0, 0, 0, 1, 1'b0, 1'b1);
        add_beats(-150, 3, 5, 600, 5);
        // second run with a pulse inside calibration
        add_beats(300, 0, 0, 0, 1, 1'b1);
        add_beats(300, 0, 0, 0, 6);
        add_beats(300, 2, 2, 1500, 12);
        add_beats(300, 4, 7, 1500, 48);
        run_reference(n_cyc);
        limit = 2 * n_cyc + 200;
        repeat (3) @(posedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        AXIS_ARESETN = 1'b1;
        for (int i = 0; i < n_cyc; i++)
        begin
            s_axis_tdata = beat_rec[i];
            start = start_rec[i];
            stop = stop_rec[i];
            @(negedge AXIS_ACLK);
        end
        // record leaves three cycles after its closing beat
        repeat (4) @(posedge AXIS_ACLK);
        if (event_exp.size() != 0 || base_exp.size() != 0)
        begin
            $display("%0d expected event records and %0d baselines never came out",
                     event_exp.size(), base_exp.size());
            $display(">>> FAIL");
            $fatal(1, "missing results");
        end
        else
        begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 4
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// File: hdl/adc_trigger_top.sv
`timescale 1ns/100ps

module adc_trigger_top #(
    parameter int THRESHOLD        = 10,
    parameter int POST_ACQUI_LEN   = 38,
    parameter int ACQUI_LEN        = 100,
    parameter int CALIB_LOG2_BEATS = 4
)
(
    input  logic                                         AXIS_ACLK,
    input  logic                                         AXIS_ARESETN,
    input  trg_pkg::adc_beat_t                           s_axis_tdata,
    input  logic                                         start,
    input  logic                                         stop,
    output trg_pkg::exec_state_e                         exec_state,
    output logic signed [trg_pkg::ADC_RESOLUTION_WIDTH-1:0] baseline,
    output logic                                         triggered,
    output logic                                         event_valid,
    output trg_pkg::trg_event_t                          event_rec
);

    logic                                        calib_done;
    logic [trg_pkg::TIME_STAMP_WIDTH-1:0]        current_time;
    logic                                        win_start;
    logic                                        win_end;
    logic                                        over_len;
    logic signed [trg_pkg::ADC_RESOLUTION_WIDTH:0] peak;
    logic [trg_pkg::LEN_WIDTH-1:0]               length;

    run_control #(
        .CALIB_LOG2_BEATS (CALIB_LOG2_BEATS)
    ) i_run_control (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .start        (start),
        .stop         (stop),
        .exec_state   (exec_state),
        .calib_done   (calib_done),
        .current_time (current_time)
    );

    baseline_calib #(
        .CALIB_LOG2_BEATS (CALIB_LOG2_BEATS)
    ) i_baseline_calib (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .s_axis_tdata (s_axis_tdata),
        .exec_state   (exec_state),
        .calib_done   (calib_done),
        .baseline     (baseline)
    );

    threshold_trigger #(
        .THRESHOLD      (THRESHOLD),
        .POST_ACQUI_LEN (POST_ACQUI_LEN),
        .ACQUI_LEN      (ACQUI_LEN)
    ) i_threshold_trigger (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .s_axis_tdata (s_axis_tdata),
        .baseline     (baseline),
        .exec_state   (exec_state),
        .triggered    (triggered),
        .win_start    (win_start),
        .win_end      (win_end),
        .over_len     (over_len),
        .peak         (peak),
        .length       (length)
    );

    event_recorder i_event_recorder (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .current_time (current_time),
        .win_start    (win_start),
        .win_end      (win_end),
        .over_len     (over_len),
        .peak         (peak),
        .length       (length),
        .event_valid  (event_valid),
        .event_rec    (event_rec)
    );

endmodule

// File: hdl/baseline_calib.sv
`timescale 1ns/100ps

module baseline_calib #(
    parameter int CALIB_LOG2_BEATS = 4
)
(
    input  logic                                         AXIS_ACLK,
    input  logic                                         AXIS_ARESETN,
    input  trg_pkg::adc_beat_t                           s_axis_tdata,
    input  trg_pkg::exec_state_e                         exec_state,
    input  logic                                         calib_done,
    output logic signed [trg_pkg::ADC_RESOLUTION_WIDTH-1:0] baseline
);

    // log2 of the number of samples in one calibration run
    localparam int SHIFT = CALIB_LOG2_BEATS + $clog2(trg_pkg::SAMPLES_PER_BEAT);

    // wide enough for the full calibration sum without overflow
    localparam int ACC_WIDTH = trg_pkg::ADC_RESOLUTION_WIDTH + SHIFT;

    logic signed [trg_pkg::ADC_RESOLUTION_WIDTH-1:0] lane_sample [trg_pkg::SAMPLES_PER_BEAT];
    logic signed [ACC_WIDTH-1:0]                     beat_sum;
    logic signed [ACC_WIDTH-1:0]                     acc;
    logic signed [ACC_WIDTH-1:0]                     acc_next;
    logic signed [ACC_WIDTH-1:0]                     avg_full;

    for (genvar i = 0; i < trg_pkg::SAMPLES_PER_BEAT; i++)
    begin : g_lane
        // padding bits above the sample are dropped
        assign lane_sample[i] = s_axis_tdata.lane[i][trg_pkg::ADC_RESOLUTION_WIDTH-1:0];
    end

    // sign-extended sum of the eight lanes
    always_comb
    begin
        beat_sum = '0;
        for (int i = 0; i < trg_pkg::SAMPLES_PER_BEAT; i++)
        begin
            beat_sum = beat_sum + lane_sample[i];
        end
    end

    assign acc_next = acc + beat_sum;

    // truncating average of all samples, including the current beat
    assign avg_full = acc_next >>> SHIFT;

    // accumulator sits at zero outside calibration
    always_ff @(posedge AXIS_ACLK)
    begin
        if (exec_state == trg_pkg::EXEC_INIT)
            acc <= acc_next;
        else
            acc <= '0;
    end

    // holds until the next calibration finishes
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
            baseline <= '0;
        else if (calib_done)
            baseline <= avg_full[trg_pkg::ADC_RESOLUTION_WIDTH-1:0];
    end

endmodule

// File: hdl/event_recorder.sv
`timescale 1ns/100ps

module event_recorder (
    input  logic                                       AXIS_ACLK,
    input  logic                                       AXIS_ARESETN,
    input  logic [trg_pkg::TIME_STAMP_WIDTH-1:0]       current_time,
    input  logic                                       win_start,
    input  logic                                       win_end,
    input  logic                                       over_len,
    input  logic signed [trg_pkg::ADC_RESOLUTION_WIDTH:0] peak,
    input  logic [trg_pkg::LEN_WIDTH-1:0]              length,
    output logic                                       event_valid,
    output trg_pkg::trg_event_t                        event_rec
);

    // current_time delayed to the beat that opened the window
    logic [trg_pkg::TIME_STAMP_WIDTH-1:0] time_d1;
    logic [trg_pkg::TIME_STAMP_WIDTH-1:0] time_d2;
    logic [trg_pkg::TIME_STAMP_WIDTH-1:0] ts_latch;

    // win_start trails the first hot beat by two cycles
    always_ff @(posedge AXIS_ACLK)
    begin
        time_d1 <= current_time;
        time_d2 <= time_d1;
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (win_start)
            ts_latch <= time_d2;
    end

    // record fields
    always_ff @(posedge AXIS_ACLK)
    begin
        if (win_end)
        begin
            event_rec.time_stamp <= ts_latch;
            event_rec.peak       <= peak;
            event_rec.length     <= length;
            event_rec.over_len   <= over_len;
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
            event_valid <= 1'b0;
        else
            event_valid <= win_end;
    end

    // windows are never back to back, so neither are records
    a_single_valid : assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        event_valid |=> !event_valid);

endmodule

// File: hdl/run_control.sv
`timescale 1ns/100ps

module run_control #(
    parameter int CALIB_LOG2_BEATS = 4
)
(
    input  logic                                   AXIS_ACLK,
    input  logic                                   AXIS_ARESETN,
    input  logic                                   start,
    input  logic                                   stop,
    output trg_pkg::exec_state_e                   exec_state,
    output logic                                   calib_done,
    output logic [trg_pkg::TIME_STAMP_WIDTH-1:0]   current_time
);

    // counts beats spent in calibration
    logic [CALIB_LOG2_BEATS-1:0] calib_cnt;
    logic                        calib_last;

    assign calib_last = (exec_state == trg_pkg::EXEC_INIT) && (calib_cnt == '1);

    // a stop on the last calibration beat wins over the move to TRG
    assign calib_done = calib_last && !stop;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            exec_state <= trg_pkg::EXEC_IDLE;
        end
        else
        begin
            case (exec_state)
                trg_pkg::EXEC_IDLE:
                begin
                    if (start)
                        exec_state <= trg_pkg::EXEC_INIT;
                end
                trg_pkg::EXEC_INIT:
                begin
                    if (stop)
                        exec_state <= trg_pkg::EXEC_IDLE;
                    else if (calib_last)
                        exec_state <= trg_pkg::EXEC_TRG;
                end
                trg_pkg::EXEC_TRG:
                begin
                    if (stop)
                        exec_state <= trg_pkg::EXEC_IDLE;
                end
                default:
                begin
                    exec_state <= trg_pkg::EXEC_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
            calib_cnt <= '0;
        else if (exec_state == trg_pkg::EXEC_INIT)
            calib_cnt <= calib_cnt + 1'b1;
        else
            calib_cnt <= '0;
    end

    // time stamps restart at zero on every entry to TRG
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
            current_time <= '0;
        else if (calib_done)
            current_time <= '0;
        else
            current_time <= current_time + 1'b1;
    end

    // calibration ends after exactly 2^CALIB_LOG2_BEATS cycles in INIT
    a_calib_done_in_init : assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        calib_done |-> (exec_state == trg_pkg::EXEC_INIT)
                       && ($past(exec_state, 2**CALIB_LOG2_BEATS - 1) == trg_pkg::EXEC_INIT)
                       && ($past(exec_state, 2**CALIB_LOG2_BEATS) == trg_pkg::EXEC_IDLE));

endmodule

// File: hdl/threshold_trigger.sv
`timescale 1ns/100ps

module threshold_trigger #(
    // percent of full scale
    parameter int THRESHOLD      = 10,
    parameter int POST_ACQUI_LEN = 38,
    // at least 2, at most 1023
    parameter int ACQUI_LEN      = 100
)
(
    input  logic                                         AXIS_ACLK,
    input  logic                                         AXIS_ARESETN,
    input  trg_pkg::adc_beat_t                           s_axis_tdata,
    input  logic signed [trg_pkg::ADC_RESOLUTION_WIDTH-1:0] baseline,
    input  trg_pkg::exec_state_e                         exec_state,
    output logic                                         triggered,
    output logic                                         win_start,
    output logic                                         win_end,
    output logic                                         over_len,
    output logic signed [trg_pkg::ADC_RESOLUTION_WIDTH:0]   peak,
    output logic [trg_pkg::LEN_WIDTH-1:0]                length
);

    localparam int ADC_W  = trg_pkg::ADC_RESOLUTION_WIDTH;
    localparam int DIFF_W = ADC_W + 1;
    localparam int LEN_W  = trg_pkg::LEN_WIDTH;
    localparam int POST_W = $clog2(POST_ACQUI_LEN + 1);

    localparam logic signed [DIFF_W-1:0] THRESHOLD_VAL = DIFF_W'((2**ADC_W - 1) * THRESHOLD / 100);
    localparam logic [LEN_W-1:0]         ACQUI_CAP     = LEN_W'(ACQUI_LEN);
    localparam logic [POST_W-1:0]        POST_LAST     = POST_W'(POST_ACQUI_LEN - 1);

    logic signed [ADC_W-1:0]  lane_sample [trg_pkg::SAMPLES_PER_BEAT];
    logic signed [DIFF_W-1:0] lane_diff [trg_pkg::SAMPLES_PER_BEAT];
    logic [trg_pkg::SAMPLES_PER_BEAT-1:0] lane_hot;
    logic signed [DIFF_W-1:0] beat_max;

    // beat state one cycle after the beat
    logic                     zone;
    logic signed [DIFF_W-1:0] zone_peak;

    logic [LEN_W-1:0]         len_cnt;
    logic [LEN_W-1:0]         len_next;
    logic [POST_W-1:0]        post_cnt;
    logic [POST_W-1:0]        post_next;
    logic signed [DIFF_W-1:0] peak_acc;
    logic signed [DIFF_W-1:0] peak_next;
    logic                     win_open;
    logic                     quiet_hit;
    logic                     cap_hit;
    logic                     win_close;

    for (genvar i = 0; i < trg_pkg::SAMPLES_PER_BEAT; i++)
    begin : g_lane
        assign lane_sample[i] = s_axis_tdata.lane[i][ADC_W-1:0];
        assign lane_diff[i]   = lane_sample[i] - baseline;
        assign lane_hot[i]    = (lane_diff[i] >= THRESHOLD_VAL);
    end

    // largest difference of the beat
    always_comb
    begin
        beat_max = lane_diff[0];
        for (int i = 1; i < trg_pkg::SAMPLES_PER_BEAT; i++)
        begin
            if (lane_diff[i] > beat_max)
                beat_max = lane_diff[i];
        end
    end

    // no triggering outside TRG
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
            zone <= 1'b0;
        else
            zone <= (exec_state == trg_pkg::EXEC_TRG) && (|lane_hot);
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        zone_peak <= beat_max;
    end

    always_comb
    begin
        win_open  = zone && !triggered;
        len_next  = (triggered ? len_cnt : '0) + 1'b1;
        post_next = zone ? '0 : post_cnt + 1'b1;
        peak_next = (triggered && (peak_acc > zone_peak)) ? peak_acc : zone_peak;
        quiet_hit = triggered && !zone && (post_cnt == POST_LAST);
        cap_hit   = (triggered || zone) && (len_next == ACQUI_CAP);
        win_close = quiet_hit || cap_hit;
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            triggered <= 1'b0;
            win_start <= 1'b0;
            win_end   <= 1'b0;
            len_cnt   <= '0;
            post_cnt  <= '0;
        end
        else
        begin
            win_start <= win_open;
            win_end   <= win_close;
            if (win_close)
            begin
                triggered <= 1'b0;
                len_cnt   <= '0;
                post_cnt  <= '0;
            end
            else if (win_open || triggered)
            begin
                triggered <= 1'b1;
                len_cnt   <= len_next;
                post_cnt  <= post_next;
            end
        end
    end

    // window result, valid with win_end
    always_ff @(posedge AXIS_ACLK)
    begin
        if (win_open || triggered)
            peak_acc <= peak_next;
        if (win_close)
        begin
            length   <= len_next;
            peak     <= peak_next;
            // a quiet close on the cap beat counts as a normal end
            over_len <= cap_hit && !quiet_hit;
        end
    end

    a_end_after_trig : assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        win_end |-> $past(triggered));

    a_len_cap : assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        win_end |-> (length <= ACQUI_CAP));

endmodule

// File: hdl/trg_pkg.sv
package trg_pkg;

    // adc sample format
    localparam int ADC_RESOLUTION_WIDTH = 12;

    // lanes per beat from the data converter
    localparam int SAMPLES_PER_BEAT = 8;

    // each sample sits in the low bits of a 16-bit lane
    localparam int LANE_WIDTH = 16;

    // run-relative time stamp
    localparam int TIME_STAMP_WIDTH = 16;

    // event length field, so ACQUI_LEN is at most 1023
    localparam int LEN_WIDTH = 10;

    // run state as seen by every block
    typedef enum logic [1:0] {
        EXEC_IDLE = 2'b00,
        EXEC_INIT = 2'b01,
        EXEC_TRG  = 2'b11
    } exec_state_e;

    // one 128-bit beat, lane 0 in the low bits
    typedef struct packed {
        logic [SAMPLES_PER_BEAT-1:0][LANE_WIDTH-1:0] lane;
    } adc_beat_t;

    // one record per finished acquisition window
    typedef struct packed {
        // current_time of the first hot beat
        logic [TIME_STAMP_WIDTH-1:0]            time_stamp;
        // largest sample minus baseline in the window
        logic signed [ADC_RESOLUTION_WIDTH:0]   peak;
        // beats from first hot beat to the closing beat
        logic [LEN_WIDTH-1:0]                   length;
        // window was cut at the beat cap
        logic                                   over_len;
    } trg_event_t;

endpackage
